// ==== src.f ====
common/board_pkg.sv
common/token_pkg.sv
led/led_stretch.sv
led/led_status.sv
source/reset_holdoff.sv
trigger/token_rx.sv
source/board_ctrl_top.sv
sim/tb_clock.sv
sim/board_ctrl_tb.sv

// ==== Makefile ====
# Verilator simulation of the board control logic

VERILATOR ?= verilator
TOP ?= board_ctrl_tb
FILELIST ?= src.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
FAIL_MSG ?= Checks failed
PASS_MSG ?= All checks passed
VFLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not finish"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/board_ctrl_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module board_ctrl_tb;

	import board_pkg::*;

	localparam int HOLDOFF = 40;
	localparam int STRETCH = 16;
	localparam int PERIOD_NS = 100;
	// Test lengths
	localparam int N_HOLD = 250;
	localparam int N_TOK = 24;
	localparam int N_ERR = 10;
	localparam int N_LED = 300;
	localparam int N_RST = 5;
	// Worst case cycles over all tests, gaps at their longest
	localparam int TEST_CYCLES = N_HOLD + 3 + N_TOK * 15 + 14 + N_ERR * 23 + 14
		+ N_LED + 20 + 2 + N_RST * 13 + 20 + 12 + 14;
	localparam int MARGIN = 200;

	logic CLK125;
	logic rst_n;
	logic ser_trig;
	logic ext_reset_n;
	logic mem_err;
	logic vme_access;
	logic cpld_access;
	logic inhibit;
	logic sys_rst;
	logic [9:0] token;
	logic tok_rdy;
	logic tok_err;
	logic [15:0] gtp_word;
	logic gtp_kchar;
	logic [LED_COUNT-1:0] led;

	logic [31:0] rng;
	string test_name;
	int error_cnt;
	// Sent tokens, parity error flag on top
	logic [10:0] exp_q[$];

	// Model state
	int m_edges;
	logic m_sys_rst;
	int m_pos;
	logic [9:0] m_frame;
	logic [9:0] m_token;
	logic m_rdy;
	logic m_err;
	logic [LED_COUNT-1:0] m_src;
	logic [LED_COUNT-1:0] m_led;
	// Edges since the LED source was last high
	int m_age[LED_COUNT];

	tb_clock #(
		.PERIOD_NS    (PERIOD_NS),
		.RESET_CYCLES (8)
	) u_tb_clock (
		.clk_o   (CLK125),
		.rst_n_o (rst_n)
	);

	board_ctrl_top #(
		.HOLDOFF_CYCLES (HOLDOFF),
		.STRETCH_CYCLES (STRETCH)
	) u_board_ctrl_top (
		.CLK125        (CLK125),
		.rst_n_i       (rst_n),
		.ser_trig_i    (ser_trig),
		.ext_reset_n_i (ext_reset_n),
		.mem_err_i     (mem_err),
		.vme_access_i  (vme_access),
		.cpld_access_i (cpld_access),
		.inhibit_i     (inhibit),
		.sys_rst_o     (sys_rst),
		.token_o       (token),
		.tok_rdy_o     (tok_rdy),
		.tok_err_o     (tok_err),
		.gtp_word_o    (gtp_word),
		.gtp_kchar_o   (gtp_kchar),
		.led_o         (led)
	);

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	// xorshift32
	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng = x;
		return x;
	endfunction

	task automatic stop_on_failure();
		$display("Checks failed");
		$fatal(1, "Simulation stopped at first error");
	endtask

	task automatic report_mismatch(input string what, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		$display("Mismatch in test %s, %s: expected %0h, actual %0h",
			test_name, what, exp_val, act_val);
		error_cnt++;
		stop_on_failure();
	endtask

	// One rising edge of the board rules, inputs sampled at the edge
	task automatic model_edge();
		logic old_sys_rst;
		logic old_rdy;
		logic old_err;
		logic [LED_COUNT-1:0] src_new;
		old_sys_rst = m_sys_rst;
		old_rdy = m_rdy;
		old_err = m_err;
		if (!rst_n) begin
			m_edges = 0;
			m_sys_rst = 1'b1;
			m_pos = 0;
			m_rdy = 1'b0;
			m_err = 1'b0;
			m_src = '0;
			m_led = '0;
			for (int i = 0; i < LED_COUNT; i++)
				m_age[i] = STRETCH;
		end else begin
			// Hold-off, then registered host request
			if (m_edges < HOLDOFF) begin
				m_sys_rst = 1'b1;
				m_edges++;
			end else begin
				m_sys_rst = ~ext_reset_n;
			end
			// Frame decoder, pos 0 idle, 1 to 10 data, 11 parity
			m_rdy = 1'b0;
			if (old_sys_rst) begin
				m_pos = 0;
			end else if (m_pos == 0) begin
				if (ser_trig)
					m_pos = 1;
			end else if (m_pos <= 10) begin
				m_frame = {m_frame[8:0], ser_trig};
				m_pos++;
			end else begin
				m_token = m_frame;
				// Even count of ones is a parity error
				m_err = ~(^{m_frame, ser_trig});
				m_rdy = 1'b1;
				m_pos = 0;
			end
			// LED sources, one register stage
			src_new[LED_ERR] = mem_err | old_sys_rst | (old_err & old_rdy);
			src_new[LED_ACCESS] = vme_access | cpld_access;
			src_new[LED_TRIG] = old_rdy;
			src_new[LED_LIVE] = ~inhibit;
			// Lit for STRETCH edges counted from the last source high
			for (int i = 0; i < LED_COUNT; i++) begin
				if (m_src[i])
					m_age[i] = 0;
				else if (m_age[i] < STRETCH)
					m_age[i]++;
				m_led[i] = (m_age[i] < STRETCH);
			end
			m_src = src_new;
		end
	endtask

	// Outputs compared on the falling edge
	task automatic check_outputs();
		logic [15:0] exp_word;
		logic [10:0] sent;
		// Status word while ready, comma otherwise
		exp_word = m_rdy ? {5'b10000, m_err, m_token} : 16'h00BC;
		assert (sys_rst === m_sys_rst)
			else report_mismatch("sys_rst_o", 32'(m_sys_rst), 32'(sys_rst));
		assert (tok_rdy === m_rdy)
			else report_mismatch("tok_rdy_o", 32'(m_rdy), 32'(tok_rdy));
		assert (tok_err === m_err)
			else report_mismatch("tok_err_o", 32'(m_err), 32'(tok_err));
		if (m_rdy)
			assert (token === m_token)
				else report_mismatch("token_o", 32'(m_token), 32'(token));
		assert (gtp_kchar === ~m_rdy)
			else report_mismatch("gtp_kchar_o", 32'(~m_rdy), 32'(gtp_kchar));
		assert (gtp_word === exp_word)
			else report_mismatch("gtp_word_o", 32'(exp_word), 32'(gtp_word));
		assert (led === m_led)
			else report_mismatch("led_o", 32'(m_led), 32'(led));
		// Token against what went out on the line
		if (tok_rdy === 1'b1 && exp_q.size() != 0) begin
			sent = exp_q.pop_front();
			assert ({tok_err, token} === sent)
				else report_mismatch("sent token", 32'(sent), 32'({tok_err, token}));
		end
	endtask

	task automatic step();
		@(posedge CLK125);
		model_edge();
		@(negedge CLK125);
		check_outputs();
	endtask

	task automatic drive_bit(input logic b);
		ser_trig = b;
		step();
	endtask

	// Start bit, ten bits MSB first, odd parity or its inverse
	task automatic send_frame(input logic [9:0] tok, input logic bad_parity,
		input logic expect_rx);
		logic par;
		par = ~(^tok) ^ bad_parity;
		if (expect_rx)
			exp_q.push_back({bad_parity, tok});
		drive_bit(1'b1);
		for (int i = 9; i >= 0; i--)
			drive_bit(tok[i]);
		drive_bit(par);
		ser_trig = 1'b0;
	endtask

	task automatic check_all_received();
		assert (exp_q.size() == 0) else begin
			$display("Test %s: %0d sent tokens never came out", test_name, exp_q.size());
			error_cnt++;
			stop_on_failure();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] r;
		ser_trig = 1'b0;
		ext_reset_n = 1'b1;
		mem_err = 1'b0;
		vme_access = 1'b0;
		cpld_access = 1'b0;
		inhibit = 1'b0;
		rng = 32'h0dbbbbaa;
		error_cnt = 0;
		m_sys_rst = 1'b1;
		m_rdy = 1'b0;
		m_err = 1'b0;

		// Hold-off runs through short host reset pulses
		test_name = "reset hold-off";
		for (int i = 0; i < N_HOLD; i++) begin
			r = next_rand();
			ext_reset_n = (r[2:0] != 3'd0);
			step();
		end

		// Good tokens, gap 0 is back to back
		test_name = "token reception";
		ext_reset_n = 1'b1;
		repeat (3) step();
		for (int i = 0; i < N_TOK; i++) begin
			r = next_rand();
			send_frame(r[9:0], 1'b0, 1'b1);
			repeat (r[13:12]) step();
		end
		repeat (14) step();
		check_all_received();

		test_name = "parity error";
		for (int i = 0; i < N_ERR; i++) begin
			r = next_rand();
			send_frame(r[9:0], 1'b1, 1'b1);
			repeat (4 + r[12:10]) step();
		end
		repeat (14) step();
		check_all_received();

		// Rare pulses retrigger, toggling levels hold
		test_name = "LED stretching";
		for (int i = 0; i < N_LED; i++) begin
			r = next_rand();
			mem_err = (r[4:0] == 5'd0);
			vme_access = (r[7:5] == 3'd0);
			if (r[11:8] == 4'd0)
				cpld_access = ~cpld_access;
			if (r[15:12] == 4'd0)
				inhibit = ~inhibit;
			step();
		end
		mem_err = 1'b0;
		vme_access = 1'b0;
		cpld_access = 1'b0;
		inhibit = 1'b0;
		repeat (20) step();

		// Frames during system reset are dropped
		test_name = "receiver in reset";
		ext_reset_n = 1'b0;
		repeat (2) step();
		for (int i = 0; i < N_RST; i++) begin
			r = next_rand();
			send_frame(r[9:0], r[10], 1'b0);
			step();
		end
		ext_reset_n = 1'b1;
		repeat (20) step();
		// Receiver back after release
		r = next_rand();
		send_frame(r[9:0], 1'b0, 1'b1);
		repeat (14) step();
		check_all_received();

		if (error_cnt == 0) begin
			$display("All checks passed");
			$finish;
		end else begin
			stop_on_failure();
		end
	end

	// Watchdog
	initial begin
		#((TEST_CYCLES + MARGIN) * PERIOD_NS);
		$display("Timeout: run did not end within %0d cycles", TEST_CYCLES + MARGIN);
		stop_on_failure();
	end

endmodule : board_ctrl_tb

`default_nettype wire

// ==== sim/tb_clock.sv ====
`timescale 1ns/10ps
`default_nettype none

// Free running CLK125 and power-on reset
module tb_clock #(
	// Clock period in ns
	parameter int PERIOD_NS = 100,
	// Rising edges with reset low
	parameter int RESET_CYCLES = 8
) (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;
	end

	// Release on a falling edge, like every other input
	initial begin
		rst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		rst_n_o = 1'b1;
	end

endmodule : tb_clock

`default_nettype wire

// ==== source/board_ctrl_top.sv ====
`timescale 1ns/10ps
`default_nettype none

////////////////////////////////////////////////////////////////////////
// Board control top
////////////////////////////////////////////////////////////////////////

module board_ctrl_top #(
	// Hold-off after power-on, CLK125 cycles
	parameter board_pkg::holdoff_cnt_t HOLDOFF_CYCLES = board_pkg::HOLDOFF_DEFAULT,
	// LED on-time, CLK125 cycles
	parameter board_pkg::holdoff_cnt_t STRETCH_CYCLES = board_pkg::STRETCH_DEFAULT
) (
	input wire CLK125,
	input wire rst_n_i,

	// Serial trigger line
	input wire ser_trig_i,
	// Host reset request, active low
	input wire ext_reset_n_i,

	// Status levels
	input wire mem_err_i,
	input wire vme_access_i,
	input wire cpld_access_i,
	input wire inhibit_i,

	// System reset, active high
	output logic sys_rst_o,

	// Token result
	output token_pkg::token_t token_o,
	output logic tok_rdy_o,
	output logic tok_err_o,

	// Word to transceivers
	output token_pkg::gtp_word_u gtp_word_o,
	output logic gtp_kchar_o,

	// Front panel
	output logic [board_pkg::LED_COUNT-1:0] led_o
);

	////////////////////////////////////////////////////////////////////////
	// Reset
	////////////////////////////////////////////////////////////////////////

	// Hold-off then follow host request
	reset_holdoff #(
		.HOLDOFF_CYCLES (HOLDOFF_CYCLES)
	) u_reset_holdoff (
		.CLK125        (CLK125),
		.rst_n_i       (rst_n_i),
		.ext_reset_n_i (ext_reset_n_i),
		.sys_rst_o     (sys_rst_o)
	);

	////////////////////////////////////////////////////////////////////////
	// Trigger token
	////////////////////////////////////////////////////////////////////////

	// Receiver idles during system reset
	token_rx u_token_rx (
		.CLK125      (CLK125),
		.rst_n_i     (rst_n_i),
		.sys_rst_i   (sys_rst_o),
		.ser_trig_i  (ser_trig_i),
		.token_o     (token_o),
		.tok_rdy_o   (tok_rdy_o),
		.tok_err_o   (tok_err_o),
		.gtp_word_o  (gtp_word_o),
		.gtp_kchar_o (gtp_kchar_o)
	);

	////////////////////////////////////////////////////////////////////////
	// LEDs
	////////////////////////////////////////////////////////////////////////

	led_status #(
		.STRETCH_CYCLES (STRETCH_CYCLES)
	) u_led_status (
		.CLK125        (CLK125),
		.rst_n_i       (rst_n_i),
		.sys_rst_i     (sys_rst_o),
		.tok_rdy_i     (tok_rdy_o),
		.tok_err_i     (tok_err_o),
		.mem_err_i     (mem_err_i),
		.vme_access_i  (vme_access_i),
		.cpld_access_i (cpld_access_i),
		.inhibit_i     (inhibit_i),
		.led_o         (led_o)
	);

endmodule : board_ctrl_top

`default_nettype wire

// ==== trigger/token_rx.sv ====
`timescale 1ns/10ps
`default_nettype none

////////////////////////////////////////////////////////////////////////
// Serial trigger token receiver
////////////////////////////////////////////////////////////////////////

// Frame, one bit per CLK125 edge
// Idle low, start bit high
// Ten token bits MSB first, then odd parity

module token_rx (
	input wire CLK125,
	input wire rst_n_i,
	// System reset, holds receiver idle
	input wire sys_rst_i,
	// Serial line
	input wire ser_trig_i,

	// Token result
	output token_pkg::token_t token_o,
	output logic tok_rdy_o,
	output logic tok_err_o,

	// Word to transceivers
	output token_pkg::gtp_word_u gtp_word_o,
	output logic gtp_kchar_o
);

	import token_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_DATA,
		ST_PARITY
	} rx_state_t;

	rx_state_t state;
	// Data bits taken so far
	logic [3:0] bit_cnt;
	// Token shift register
	token_t shift_q;

	////////////////////////////////////////////////////////////////////////
	// Control FSM
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK125) begin
		if (!rst_n_i || sys_rst_i) begin
			state <= ST_IDLE;
			bit_cnt <= '0;
			tok_rdy_o <= 1'b0;
		end else begin
			// Strobe by default
			tok_rdy_o <= 1'b0;
			case (state)
				ST_IDLE: begin
					// Start bit
					if (ser_trig_i) begin
						state <= ST_DATA;
						bit_cnt <= '0;
					end
				end
				ST_DATA: begin
					bit_cnt <= bit_cnt + 1'b1;
					// Last token bit
					if (bit_cnt == 4'(TOKEN_W - 1))
						state <= ST_PARITY;
				end
				ST_PARITY: begin
					// Result out, ready for next start bit
					tok_rdy_o <= 1'b1;
					state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Flag goes with the token
	always_ff @(posedge CLK125) begin
		if (!rst_n_i)
			tok_err_o <= 1'b0;
		else if (state == ST_PARITY && !sys_rst_i)
			// Even count of ones is an error
			tok_err_o <= ~(^{shift_q, ser_trig_i});
	end

	////////////////////////////////////////////////////////////////////////
	// Data path
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK125) begin
		// MSB arrives first
		if (state == ST_DATA)
			shift_q <= {shift_q[TOKEN_W-2:0], ser_trig_i};
		// Hold token until the next frame
		if (state == ST_PARITY)
			token_o <= shift_q;
	end

	// Status word for one cycle, comma otherwise
	always_comb begin
		gtp_word_o = '0;
		if (tok_rdy_o) begin
			gtp_word_o.status.marker = STATUS_MARKER;
			gtp_word_o.status.err = tok_err_o;
			gtp_word_o.status.token = token_o;
		end else begin
			gtp_word_o.comma = COMMA_K;
		end
	end

	// K-char only for comma
	assign gtp_kchar_o = ~tok_rdy_o;

	////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////

	// Single cycle ready strobe
	a_rdy_pulse : assert property (
		@(posedge CLK125) disable iff (!rst_n_i)
		tok_rdy_o |=> !tok_rdy_o
	);

	// Word view agrees with the K-character flag
	a_kchar : assert property (
		@(posedge CLK125) disable iff (!rst_n_i)
		gtp_kchar_o ? (gtp_word_o.comma == COMMA_K)
			: (gtp_word_o.status.marker == STATUS_MARKER)
	);

endmodule : token_rx

`default_nettype wire

// ==== source/reset_holdoff.sv ====
`timescale 1ns/10ps
`default_nettype none

////////////////////////////////////////////////////////////////////////
// Power-on reset hold-off
////////////////////////////////////////////////////////////////////////

module reset_holdoff #(
	// Edges after release before the request is followed
	parameter board_pkg::holdoff_cnt_t HOLDOFF_CYCLES = board_pkg::HOLDOFF_DEFAULT
) (
	input wire CLK125,
	input wire rst_n_i,
	// Host reset request, active low
	input wire ext_reset_n_i,
	// System reset, active high
	output logic sys_rst_o
);

	import board_pkg::*;

	// Hold-off counter, stops at HOLDOFF_CYCLES
	holdoff_cnt_t holdoff_cnt;
	// Hold-off over
	logic holdoff_done;

	assign holdoff_done = (holdoff_cnt == HOLDOFF_CYCLES);

	always_ff @(posedge CLK125) begin
		if (!rst_n_i) begin
			holdoff_cnt <= '0;
			sys_rst_o <= 1'b1;
		end else begin
			// Count up and saturate
			if (!holdoff_done)
				holdoff_cnt <= holdoff_cnt + 1'b1;
			// Keep reset during hold-off
			// then register the inverted request
			if (holdoff_done)
				sys_rst_o <= ~ext_reset_n_i;
			else
				sys_rst_o <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////

	// No release of system reset before the hold-off runs out
	a_holdoff_rst : assert property (
		@(posedge CLK125) disable iff (!rst_n_i)
		(holdoff_cnt < HOLDOFF_CYCLES) |-> sys_rst_o
	);

endmodule : reset_holdoff

`default_nettype wire

// ==== led/led_status.sv ====
`timescale 1ns/10ps
`default_nettype none

////////////////////////////////////////////////////////////////////////
// Front panel LED sources
////////////////////////////////////////////////////////////////////////

module led_status #(
	// LED on-time, CLK125 cycles
	parameter board_pkg::holdoff_cnt_t STRETCH_CYCLES = board_pkg::STRETCH_DEFAULT
) (
	input wire CLK125,
	input wire rst_n_i,
	// Error sources
	input wire sys_rst_i,
	input wire tok_rdy_i,
	input wire tok_err_i,
	input wire mem_err_i,
	// Access sources
	input wire vme_access_i,
	input wire cpld_access_i,
	// Inhibit level
	input wire inhibit_i,
	output wire [board_pkg::LED_COUNT-1:0] led_o
);

	import board_pkg::*;

	// Registered LED sources
	logic [LED_COUNT-1:0] led_src;

	always_ff @(posedge CLK125) begin
		if (!rst_n_i) begin
			led_src <= '0;
		end else begin
			// Memory error, system reset or bad token
			led_src[LED_ERR] <= mem_err_i | sys_rst_i | (tok_err_i & tok_rdy_i);
			// VME access to this card or to CPLD
			led_src[LED_ACCESS] <= vme_access_i | cpld_access_i;
			// Master trigger received
			led_src[LED_TRIG] <= tok_rdy_i;
			// No inhibit
			led_src[LED_LIVE] <= ~inhibit_i;
		end
	end

	// One stretcher per LED
	for (genvar i = 0; i < LED_COUNT; i++) begin : g_led
		led_stretch #(
			.STRETCH_CYCLES (STRETCH_CYCLES)
		) u_led_stretch (
			.CLK125  (CLK125),
			.rst_n_i (rst_n_i),
			.trig_i  (led_src[i]),
			.led_o   (led_o[i])
		);
	end

endmodule : led_status

`default_nettype wire

// ==== led/led_stretch.sv ====
`timescale 1ns/10ps
`default_nettype none

////////////////////////////////////////////////////////////////////////
// LED on-time stretcher
////////////////////////////////////////////////////////////////////////

// Retriggerable, lit for STRETCH_CYCLES after last trigger

module led_stretch #(
	// On-time, CLK125 cycles
	parameter board_pkg::holdoff_cnt_t STRETCH_CYCLES = board_pkg::STRETCH_DEFAULT
) (
	input wire CLK125,
	input wire rst_n_i,
	// Registered LED source
	input wire trig_i,
	output logic led_o
);

	import board_pkg::*;

	// Remaining on-time
	holdoff_cnt_t on_cnt;

	always_ff @(posedge CLK125) begin
		if (!rst_n_i) begin
			on_cnt <= '0;
			led_o <= 1'b0;
		end else if (trig_i) begin
			// Reload on every trigger
			on_cnt <= STRETCH_CYCLES;
			led_o <= 1'b1;
		end else if (on_cnt != '0) begin
			on_cnt <= on_cnt - 1'b1;
			// Dark once the count hits zero
			led_o <= (on_cnt != holdoff_cnt_t'(1));
		end
	end

	////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////

	// LED matches a running timer
	a_dark_at_zero : assert property (
		@(posedge CLK125) disable iff (!rst_n_i)
		(on_cnt == '0) |-> !led_o
	);

endmodule : led_stretch

`default_nettype wire

// ==== common/token_pkg.sv ====
`default_nettype none

////////////////////////////////////////////////////////////////////////
// Serial trigger token and transceiver word layout
////////////////////////////////////////////////////////////////////////

package token_pkg;

	// Token width on the serial line
	localparam int unsigned TOKEN_W = 10;

	// Received trigger token
	typedef logic [TOKEN_W-1:0] token_t;

	// Comma sent between tokens as K-character
	localparam logic [15:0] COMMA_K = 16'h00BC;

	// Top bits of a status word
	localparam logic [4:0] STATUS_MARKER = 5'b10000;

	// Status word sent once per received token
	typedef struct packed {
		// Fixed marker, STATUS_MARKER
		logic [4:0] marker;
		// Parity error of this token
		logic err;
		// Token itself
		token_t token;
	} tok_status_t;

	////////////////////////////////////////////////////////////////////////
	// Transceiver word
	////////////////////////////////////////////////////////////////////////

	// Same 16 bits, read by the K-character flag
	// Flag low means status view
	// Flag high means comma code
	typedef union packed {
		tok_status_t status;
		logic [15:0] comma;
	} gtp_word_u;

endpackage : token_pkg

`default_nettype wire

// ==== common/board_pkg.sv ====
`default_nettype none

////////////////////////////////////////////////////////////////////////
// Board control constants
////////////////////////////////////////////////////////////////////////

package board_pkg;

	// Front panel LED count
	localparam int unsigned LED_COUNT = 4;

	// LED order, top to bottom on the panel
	// Yellow, memory or token error
	localparam int unsigned LED_ERR = 0;
	// Green, VME or CPLD access
	localparam int unsigned LED_ACCESS = 1;
	// Green, master trigger received
	localparam int unsigned LED_TRIG = 2;
	// Green, lit while no inhibit
	localparam int unsigned LED_LIVE = 3;

	// Wide counter for long CLK125 intervals
	typedef logic [31:0] holdoff_cnt_t;

	// Power-on hold-off, 8 ms at 125 MHz
	localparam holdoff_cnt_t HOLDOFF_DEFAULT = 32'd1_000_000;

	// LED on-time, 100 ms at 125 MHz
	localparam holdoff_cnt_t STRETCH_DEFAULT = 32'd12_500_000;

endpackage : board_pkg

`default_nettype wire
